//--- logic/dist_pkg.sv
package dist_pkg;

    // width of one data word on the fanout tree
    localparam int DIST_DATA_W = 32;

    // one word as it travels from the root to the leaves
    typedef logic [DIST_DATA_W-1:0] dist_word_t;

    // beat used at the tree input and on every leaf port
    // valid sits on top, payload below it
    // a pruned or flushed beat is all zero
    typedef struct packed {
        logic       valid;
        dist_word_t data;
    } dist_beat_t;

endpackage

//--- logic/cfg_pkg.sv
package cfg_pkg;

    // mask field width, upper bound on the leaf count
    localparam int CFG_MAX_LEAVES = 16;

    // register block opcodes
    // codes 6 and 7 are not defined
    typedef enum logic [2:0] {
        CFG_NOP      = 3'd0,
        // load the whole mask
        CFG_SET_MASK = 3'd1,
        // set the given bits
        CFG_OR_MASK  = 3'd2,
        // clear the given bits
        CFG_CLR_MASK = 3'd3,
        CFG_ENABLE   = 3'd4,
        CFG_DISABLE  = 3'd5
    } cfg_op_e;

    // one command, strobed by a write enable
    typedef struct packed {
        cfg_op_e                   op;
        logic [CFG_MAX_LEAVES-1:0] arg;
    } cfg_cmd_t;

    // live configuration seen by the tree
    typedef struct packed {
        logic                      enable;
        logic [CFG_MAX_LEAVES-1:0] dest_mask;
    } cfg_regs_t;

endpackage

//--- logic/dist_cfg_regs.sv
module dist_cfg_regs #(
    parameter int NUM_LEAVES = 8
) (
    input  logic              CLK,
    input  logic              i_arst_n,
    input  logic              i_cmd_we,
    input  cfg_pkg::cfg_cmd_t i_cmd,
    output cfg_pkg::cfg_regs_t o_regs
);

    // ones over the leaves that exist, zero above
    localparam logic [cfg_pkg::CFG_MAX_LEAVES-1:0] LEAF_MASK =
        {cfg_pkg::CFG_MAX_LEAVES{1'b1}} >> (cfg_pkg::CFG_MAX_LEAVES - NUM_LEAVES);

    cfg_pkg::cfg_regs_t regs_q;
    cfg_pkg::cfg_regs_t regs_d;

    // command decode
    always_comb
    begin
        regs_d = regs_q;
        if (i_cmd_we)
        begin
            case (i_cmd.op)
                // full load, bits above the leaf count dropped
                cfg_pkg::CFG_SET_MASK:
                    regs_d.dest_mask = i_cmd.arg & LEAF_MASK;
                // add leaves to the current set
                cfg_pkg::CFG_OR_MASK:
                    regs_d.dest_mask = (regs_q.dest_mask | i_cmd.arg) & LEAF_MASK;
                // remove leaves from the current set
                cfg_pkg::CFG_CLR_MASK:
                    regs_d.dest_mask = regs_q.dest_mask & ~i_cmd.arg;
                cfg_pkg::CFG_ENABLE:
                    regs_d.enable = 1'b1;
                // tree flushes on the next edge
                cfg_pkg::CFG_DISABLE:
                    regs_d.enable = 1'b0;
                // nop, nothing changes
                default:
                    regs_d = regs_q;
            endcase
        end
    end

    // out of reset the tree is off and aimed at every leaf
    always_ff @(posedge CLK or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            regs_q.enable    <= 1'b0;
            regs_q.dest_mask <= LEAF_MASK;
        end
        else
        begin
            regs_q <= regs_d;
        end
    end

    // visible right after the edge that took the command
    assign o_regs = regs_q;

    // only defined opcodes get strobed
    a_op_defined: assert property (
        @(posedge CLK) disable iff (!i_arst_n)
        i_cmd_we |-> i_cmd.op inside {cfg_pkg::CFG_NOP, cfg_pkg::CFG_SET_MASK,
                                      cfg_pkg::CFG_OR_MASK, cfg_pkg::CFG_CLR_MASK,
                                      cfg_pkg::CFG_ENABLE, cfg_pkg::CFG_DISABLE}
    ) else $error("undefined opcode %0h strobed", i_cmd.op);

    // no mask bit for a leaf that is not built
    a_mask_upper_zero: assert property (
        @(posedge CLK) disable iff (!i_arst_n)
        (o_regs.dest_mask & ~LEAF_MASK) == '0
    ) else $error("dest_mask %0h has bits above leaf %0d", o_regs.dest_mask, NUM_LEAVES);

endmodule

//--- logic/dist_tree.sv
module dist_tree #(
    parameter int NUM_LEAVES = 8
) (
    input  logic                                  CLK,
    input  logic                                  i_arst_n,
    input  cfg_pkg::cfg_regs_t                    i_regs,
    input  dist_pkg::dist_beat_t                  i_beat,
    output dist_pkg::dist_beat_t [NUM_LEAVES-1:0] o_leaf
);

    // root is level 0, leaves are level NUM_LEVELS
    localparam int NUM_LEVELS = $clog2(NUM_LEAVES);

    // leaf count must be a power of two that fits the mask
    if (NUM_LEAVES < 2 || NUM_LEAVES > cfg_pkg::CFG_MAX_LEAVES ||
        (NUM_LEAVES & (NUM_LEAVES - 1)) != 0)
    begin : g_bad_leaves
        $error("NUM_LEAVES %0d not a power of two in 2..%0d",
               NUM_LEAVES, cfg_pkg::CFG_MAX_LEAVES);
    end

    for (genvar l = 0; l <= NUM_LEVELS; l++)
    begin : g_lvl
        // nodes on this level and leaves under each node
        localparam int NODES = 1 << l;
        localparam int SPAN  = NUM_LEAVES >> l;

        logic [NODES-1:0]                  valid_q;
        dist_pkg::dist_word_t [NODES-1:0]  data_q;

        // parent side of every node on this level
        logic [NODES-1:0]                  src_valid;
        dist_pkg::dist_word_t [NODES-1:0]  src_data;
        logic [NUM_LEAVES-1:0]             src_mask;
        logic [NODES-1:0]                  keep;
        dist_pkg::dist_word_t [NODES-1:0]  keep_data;

        // mask enters with the beat at the root
        // deeper levels use the copy that rode along
        if (l == 0)
        begin : g_msrc
            assign src_mask = i_regs.dest_mask[NUM_LEAVES-1:0];
        end
        else
        begin : g_msrc
            assign src_mask = g_lvl[l-1].g_fwd.mask_q;
        end

        for (genvar n = 0; n < NODES; n++)
        begin : g_node
            if (l == 0)
            begin : g_src
                assign src_valid[n] = i_beat.valid;
                assign src_data[n]  = i_beat.data;
            end
            else
            begin : g_src
                // both children copy the same parent
                assign src_valid[n] = g_lvl[l-1].valid_q[n/2];
                assign src_data[n]  = g_lvl[l-1].data_q[n/2];
            end
            // prune when no leaf below this node is selected
            assign keep[n]      = src_valid[n] & (|src_mask[n*SPAN +: SPAN]);
            // pruned subtree stays quiet, zero payload
            assign keep_data[n] = keep[n] ? src_data[n] : '0;
        end

        // valid is control state, cleared by reset and on disable
        always_ff @(posedge CLK or negedge i_arst_n)
        begin
            if (!i_arst_n)
                valid_q <= '0;
            else if (!i_regs.enable)
                valid_q <= '0;
            else
                valid_q <= keep;
        end

        // payload flushes to zero while the tree is off
        always_ff @(posedge CLK)
        begin
            if (!i_regs.enable)
                data_q <= '0;
            else
                data_q <= keep_data;
        end

        // mask copy rides next to the beat, not needed past the last split
        if (l < NUM_LEVELS)
        begin : g_fwd
            logic [NUM_LEAVES-1:0] mask_q;

            always_ff @(posedge CLK)
            begin
                if (!i_regs.enable)
                    mask_q <= '0;
                else
                    mask_q <= src_mask;
            end
        end
    end

    for (genvar k = 0; k < NUM_LEAVES; k++)
    begin : g_leaf
        assign o_leaf[k].valid = g_lvl[NUM_LEVELS].valid_q[k];
        assign o_leaf[k].data  = g_lvl[NUM_LEVELS].data_q[k];

        // leaf valid only if its mask bit was set when the beat entered
        a_leaf_masked: assert property (
            @(posedge CLK) disable iff (!i_arst_n)
            o_leaf[k].valid |-> $past(i_beat.valid & i_regs.dest_mask[k], NUM_LEVELS + 1)
        ) else $error("leaf %0d valid without mask bit at entry", k);
    end

    // whole pipe empty one edge after enable drops
    a_flush: assert property (
        @(posedge CLK) disable iff (!i_arst_n)
        $fell(i_regs.enable) |=> o_leaf == '0
    ) else $error("leaves not flushed after disable");

endmodule

//--- logic/dist_top.sv
module dist_top #(
    // power of two, 2 to 16
    parameter int NUM_LEAVES = 8
) (
    input  logic                                  CLK,
    input  logic                                  i_arst_n,
    input  logic                                  i_cmd_we,
    input  cfg_pkg::cfg_cmd_t                     i_cmd,
    input  dist_pkg::dist_beat_t                  i_beat,
    output dist_pkg::dist_beat_t [NUM_LEAVES-1:0] o_leaf
);

    // enable and mask from the register block into the tree
    cfg_pkg::cfg_regs_t cfg_regs;

    // command decode, mask limited to the built leaves
    dist_cfg_regs #(
        .NUM_LEAVES (NUM_LEAVES)
    ) u_cfg_regs (
        .CLK      (CLK),
        .i_arst_n (i_arst_n),
        .i_cmd_we (i_cmd_we),
        .i_cmd    (i_cmd),
        .o_regs   (cfg_regs)
    );

    // registered fanout, 1 + log2(NUM_LEAVES) cycles root to leaf
    dist_tree #(
        .NUM_LEAVES (NUM_LEAVES)
    ) u_tree (
        .CLK      (CLK),
        .i_arst_n (i_arst_n),
        .i_regs   (cfg_regs),
        .i_beat   (i_beat),
        .o_leaf   (o_leaf)
    );

endmodule

//--- tb/tb_clk_gen.sv
module tb_clk_gen #(
    // full period in ns
    parameter int PERIOD = 4
) (
    output logic o_clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // starts low, first rising edge half a period in
    initial
    begin
        o_clk = 1'b0;
        forever
            #(PERIOD / 2.0) o_clk = ~o_clk;
    end

endmodule

//--- tb/tb_dist_top.sv
module tb_dist_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_LEAVES = 8;
    // stage 0 plus one register per tree level
    localparam int PIPE_DEPTH = $clog2(NUM_LEAVES) + 1;
    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 8;
    localparam logic [31:0] LFSR_SEED = 32'h9684437b;
    localparam logic [31:0] LFSR_TAPS = 32'hA3000000;
    localparam logic [NUM_LEAVES-1:0] LEAF_ONES = '1;

    // test lengths in cycles
    localparam int N_IDLE = 10;
    localparam int N_BCAST = 32;
    localparam int N_GROUPS = 8;
    localparam int GROUP_LEN = 6;
    localparam int N_FLIGHT = 32;
    localparam int N_ROUNDS = 4;
    localparam int N_PRE_OFF = 4;
    localparam int N_OFF = 6;
    localparam int N_RESUME = 12;
    // enough idle cycles for the last beat to be checked
    localparam int DRAIN = PIPE_DEPTH + 2;
    localparam int RUN_CYCLES = RST_CYCLES + N_IDLE + (2 + N_BCAST + DRAIN)
        + (N_GROUPS * (1 + GROUP_LEN) + DRAIN) + (N_FLIGHT + DRAIN)
        + (N_ROUNDS * 7 + DRAIN) + (N_PRE_OFF + 2 + N_OFF + N_RESUME + DRAIN);
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + 50;

    // one beat in the model delay line with the mask it was taken with
    typedef struct packed {
        logic                  valid;
        dist_pkg::dist_word_t  data;
        logic [NUM_LEAVES-1:0] mask;
    } slot_t;

    logic                                  CLK;
    logic                                  i_arst_n;
    logic                                  cmd_we;
    cfg_pkg::cfg_cmd_t                     cmd;
    dist_pkg::dist_beat_t                  beat;
    dist_pkg::dist_beat_t [NUM_LEAVES-1:0] leaf;

    // reference model state
    logic                                  model_en;
    logic [NUM_LEAVES-1:0]                 model_mask;
    slot_t [PIPE_DEPTH-1:0]                dl_q;
    logic [NUM_LEAVES-1:0]                 exp_valid;
    dist_pkg::dist_word_t [NUM_LEAVES-1:0] exp_data;

    logic [31:0] lfsr;
    int          err_cnt = 0;
    int          err_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    tb_clk_gen #(
        .PERIOD (CLK_PERIOD)
    ) u_clk_gen (
        .o_clk (CLK)
    );

    dist_top #(
        .NUM_LEAVES (NUM_LEAVES)
    ) u_dist_top (
        .CLK      (CLK),
        .i_arst_n (i_arst_n),
        .i_cmd_we (cmd_we),
        .i_cmd    (cmd),
        .i_beat   (beat),
        .o_leaf   (leaf)
    );

    // model of the enable and mask registers and the delay line
    // a low enable empties every slot
    always @(posedge CLK or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            model_en   <= 1'b0;
            model_mask <= LEAF_ONES;
            dl_q       <= '0;
        end
        else
        begin
            if (cmd_we)
            begin
                case (cmd.op)
                    cfg_pkg::CFG_SET_MASK:
                        model_mask <= cmd.arg[NUM_LEAVES-1:0];
                    cfg_pkg::CFG_OR_MASK:
                        model_mask <= model_mask | cmd.arg[NUM_LEAVES-1:0];
                    cfg_pkg::CFG_CLR_MASK:
                        model_mask <= model_mask & ~cmd.arg[NUM_LEAVES-1:0];
                    cfg_pkg::CFG_ENABLE:
                        model_en <= 1'b1;
                    cfg_pkg::CFG_DISABLE:
                        model_en <= 1'b0;
                    default:
                        model_en <= model_en;
                endcase
            end
            if (!model_en)
                dl_q <= '0;
            else
            begin
                // beat pairs with the mask in force at this edge
                dl_q[0] <= '{valid: beat.valid, data: beat.data, mask: model_mask};
                for (int s = 1; s < PIPE_DEPTH; s++)
                    dl_q[s] <= dl_q[s-1];
            end
        end
    end

    // leaves outside the mask see no beat and zero data
    always_comb
    begin
        for (int k = 0; k < NUM_LEAVES; k++)
        begin
            exp_valid[k] = dl_q[PIPE_DEPTH-1].valid & dl_q[PIPE_DEPTH-1].mask[k];
            exp_data[k]  = exp_valid[k] ? dl_q[PIPE_DEPTH-1].data : '0;
        end
    end

    for (genvar k = 0; k < NUM_LEAVES; k++)
    begin : g_chk
        // valid checked through reset too
        a_leaf_valid: assert property (
            @(posedge CLK) leaf[k].valid === exp_valid[k]
        ) else
        begin
            err_cnt++;
            $display("CHECK FAILED u_dist_top.o_leaf[%0d].valid expected %h got %h",
                     k, $sampled(exp_valid[k]), $sampled(leaf[k].valid));
        end

        a_leaf_data: assert property (
            @(posedge CLK) disable iff (!i_arst_n) leaf[k].data === exp_data[k]
        ) else
        begin
            err_cnt++;
            $display("CHECK FAILED u_dist_top.o_leaf[%0d].data expected %h got %h",
                     k, $sampled(exp_data[k]), $sampled(leaf[k].data));
        end
    end

    // tree quiet once enable has been low for a full cycle
    a_flush_quiet: assert property (
        @(posedge CLK) disable iff (!i_arst_n)
        (!model_en && !$past(model_en)) |-> leaf == '0
    ) else
    begin
        err_cnt++;
        $display("CHECK FAILED u_dist_top.o_leaf expected %h got %h",
                 {NUM_LEAVES * $bits(dist_pkg::dist_beat_t){1'b0}}, $sampled(leaf));
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic dist_pkg::dist_beat_t random_beat(input logic valid);
        dist_pkg::dist_beat_t b;
        b.valid = valid;
        b.data  = next_bits(dist_pkg::DIST_DATA_W);
        return b;
    endfunction

    // drive right after a rising edge and wait for the next one
    task automatic drive_cycle(input logic we, input cfg_pkg::cfg_op_e op,
                               input logic [15:0] arg, input dist_pkg::dist_beat_t b);
        cmd_we <= we;
        cmd    <= '{op: op, arg: arg};
        beat   <= b;
        @(posedge CLK);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
            drive_cycle(1'b0, cfg_pkg::CFG_NOP, '0, random_beat(1'b0));
    endtask

    task automatic offer_beats(input int n);
        repeat (n)
            drive_cycle(1'b0, cfg_pkg::CFG_NOP, '0, random_beat(1'b1));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt == err_mark)
            $display("test %0d %s: passed", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed, %0d mismatches", tests_run, name,
                     err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    // random mask reload before each group of beats
    task automatic multicast_groups();
        logic [15:0] arg;
        for (int g = 0; g < N_GROUPS; g++)
        begin
            arg = 16'(next_bits(16));
            drive_cycle(1'b1, cfg_pkg::CFG_SET_MASK, arg, random_beat(1'b0));
            offer_beats(GROUP_LEN);
        end
        idle_cycles(DRAIN);
    endtask

    // new mask on every cycle with beats back to back
    task automatic retarget_in_flight();
        logic [15:0] arg;
        for (int i = 0; i < N_FLIGHT; i++)
        begin
            arg = 16'(next_bits(16));
            drive_cycle(1'b1, cfg_pkg::CFG_SET_MASK, arg, random_beat(1'b1));
        end
        idle_cycles(DRAIN);
    endtask

    // load, set bits, clear bits and nop with beats in between
    task automatic apply_mask_ops();
        logic [15:0] arg;
        for (int r = 0; r < N_ROUNDS; r++)
        begin
            arg = 16'(next_bits(16));
            drive_cycle(1'b1, cfg_pkg::CFG_SET_MASK, arg, random_beat(1'b1));
            offer_beats(1);
            arg = 16'(next_bits(16));
            drive_cycle(1'b1, cfg_pkg::CFG_OR_MASK, arg, random_beat(1'b1));
            offer_beats(1);
            arg = 16'(next_bits(16));
            drive_cycle(1'b1, cfg_pkg::CFG_CLR_MASK, arg, random_beat(1'b1));
            offer_beats(1);
            drive_cycle(1'b1, cfg_pkg::CFG_NOP, '1, random_beat(1'b1));
        end
        idle_cycles(DRAIN);
    endtask

    // disable with beats in flight and resume
    task automatic flush_and_resume();
        drive_cycle(1'b1, cfg_pkg::CFG_SET_MASK, '1, random_beat(1'b0));
        offer_beats(N_PRE_OFF - 1);
        // enable still high at this edge so the beat is taken
        drive_cycle(1'b1, cfg_pkg::CFG_DISABLE, '0, random_beat(1'b1));
        idle_cycles(N_OFF);
        drive_cycle(1'b1, cfg_pkg::CFG_ENABLE, '0, random_beat(1'b0));
        offer_beats(N_RESUME);
        idle_cycles(DRAIN);
    endtask

    initial
    begin
        lfsr     = LFSR_SEED;
        i_arst_n = 1'b1;
        cmd_we   = 1'b0;
        cmd      = '0;
        beat     = '0;
        #1;
        i_arst_n = 1'b0;
        repeat (RST_CYCLES)
            @(posedge CLK);
        i_arst_n <= 1'b1;

        // tree still disabled with only invalid beats
        idle_cycles(N_IDLE);
        end_test("reset and idle");

        drive_cycle(1'b1, cfg_pkg::CFG_SET_MASK, '1, random_beat(1'b0));
        drive_cycle(1'b1, cfg_pkg::CFG_ENABLE, '0, random_beat(1'b0));
        offer_beats(N_BCAST);
        idle_cycles(DRAIN);
        end_test("broadcast");

        multicast_groups();
        end_test("multicast pruning");

        retarget_in_flight();
        end_test("mask change in flight");

        apply_mask_ops();
        end_test("mask operations");

        flush_and_resume();
        end_test("disable flush");

        $display("summary: %0d tests passed, %0d tests failed, %0d check failures",
                 tests_run - tests_failed, tests_failed, err_cnt);
        if (err_cnt == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // bound on the whole run
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- all.f
logic/dist_pkg.sv
logic/cfg_pkg.sv
logic/dist_cfg_regs.sv
logic/dist_tree.sv
logic/dist_top.sv
tb/tb_clk_gen.sv
tb/tb_dist_top.sv

//--- Bender.yml
package:
  name: dist_fanout

sources:
  # packages first, then the blocks that use them
  - logic/dist_pkg.sv
  - logic/cfg_pkg.sv
  - logic/dist_cfg_regs.sv
  - logic/dist_tree.sv
  - logic/dist_top.sv
  - target: simulation
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_dist_top.sv
